// File: design/pm_consts.svh
// ****************************************
// P-M sequencer word, register, counter
// and instruction field widths
// ****************************************

`ifndef PM_CONSTS_SVH
`define PM_CONSTS_SVH

// data path widths
`define PM_WORD_W 16
`define PM_REG_W 3
`define PM_LK_W 4
`define PM_MC_W 2

// instruction field positions
`define PM_CL_W 3
`define PM_CL_LSB 13
`define PM_RA_LSB 10
`define PM_RB_LSB 7
`define PM_IND_BIT 6
`define PM_MC_LSB 4
`define PM_LK_LSB 0

`endif

// File: design/pm_pkg.sv
// ****************************************
// P-M sequencer shared types: states,
// instruction classes, panel and W-bus ops
// ****************************************

package pm_pkg;

	// main loop states
	typedef enum logic [2:0] {
		ST_WAIT,
		ST_P0,
		ST_P1,
		ST_P2,
		ST_P3,
		ST_P4,
		ST_P5,
		ST_INT
	} pm_state_t;

	// instruction class, from the top three word bits
	typedef enum logic [2:0] {
		CL_REG,
		CL_MEM,
		CL_SHIFT,
		CL_GROUP,
		CL_IO,
		CL_JUMP,
		CL_HALT,
		CL_NOP
	} instr_class_t;

	// control panel commands
	typedef enum logic [2:0] {
		PNL_NONE, PNL_START, PNL_STOP, PNL_CYCLE, PNL_LOAD
	} panel_op_t;

	// W bus destination microoperations
	typedef enum logic [2:0] {
		WOP_NONE, WOP_R, WOP_AC, WOP_AR, WOP_IC
	} w_op_t;

endpackage

// File: design/pm_panel_regs.sv
// ****************************************
// control panel flags: start, wait, single
// cycle and pending register load
// ****************************************

`timescale 1ns/100ps

`include "pm_consts.svh"

module pm_panel_regs (
	input  logic                   setwp,
	input  logic                   __m77,
	input  logic                   panel_stb,
	input  pm_pkg::panel_op_t      panel_op,
	input  logic [`PM_REG_W-1:0]   panel_reg,
	input  logic                   load_done,
	input  logic                   halt_seen,
	input  logic                   cycle_end,
	output logic                   go,
	output logic                   single,
	output logic                   load_req,
	output logic                   run,
	output logic                   wait_flag,
	output logic [`PM_REG_W-1:0]   panel_reg_q
);

	logic start_q;
	logic wait_q;
	logic single_q;
	logic load_q;

	// a panel command overrides a sequencer event in the same cycle
	always_ff @(posedge setwp or posedge __m77) begin
		if (__m77) begin
			start_q <= 1'b0;
			wait_q <= 1'b0;
			single_q <= 1'b0;
			load_q <= 1'b0;
		end else begin
			if (cycle_end)
				start_q <= 1'b0;
			if (halt_seen)
				wait_q <= 1'b1;
			if (load_done)
				load_q <= 1'b0;
			if (panel_stb) begin
				case (panel_op)
					pm_pkg::PNL_START: begin
						start_q <= 1'b1;
						wait_q <= 1'b0;
						single_q <= 1'b0;
					end
					pm_pkg::PNL_CYCLE: begin
						start_q <= 1'b1;
						single_q <= 1'b1;
					end
					// go drops at once and the running instruction still completes
					pm_pkg::PNL_STOP: start_q <= 1'b0;
					pm_pkg::PNL_LOAD: load_q <= 1'b1;
					default: ;
				endcase
			end
		end
	end

	// register index latched by a panel load
	always_ff @(posedge setwp) begin
		if (panel_stb && panel_op == pm_pkg::PNL_LOAD)
			panel_reg_q <= panel_reg;
	end

	assign go = start_q & ~wait_q;
	assign run = start_q & ~wait_q;
	assign single = single_q;
	assign load_req = load_q;
	assign wait_flag = wait_q;

endmodule

// File: design/pm_counters.sv
// ****************************************
// premodification, group and step counters
// ****************************************

`timescale 1ns/100ps

`include "pm_consts.svh"

module pm_counters (
	input  logic                  setwp,
	input  logic                  __m77,
	input  logic                  mc_clr,
	input  logic                  mc_inc,
	input  logic                  lg_clr,
	input  logic                  lg_inc,
	input  logic                  lk_load,
	input  logic                  lk_dec,
	input  logic [`PM_LK_W-1:0]   lk_init,
	output logic [`PM_MC_W-1:0]   mc,
	output logic [1:0]            lg,
	output logic                  lk_zero
);

	logic [`PM_LK_W-1:0] lk;

	// premodification counter
	always_ff @(posedge setwp or posedge __m77) begin
		if (__m77)
			mc <= '0;
		else if (mc_clr)
			mc <= '0;
		else if (mc_inc)
			mc <= mc + 1'b1;
	end

	// group counter walking the register group
	always_ff @(posedge setwp or posedge __m77) begin
		if (__m77)
			lg <= 2'd0;
		else if (lg_clr)
			lg <= 2'd0;
		else if (lg_inc)
			lg <= lg + 2'd1;
	end

	// step counter loaded from the shift field and counted down
	always_ff @(posedge setwp or posedge __m77) begin
		if (__m77)
			lk <= '0;
		else if (lk_load)
			lk <= lk_init;
		else if (lk_dec && !lk_zero)
			lk <= lk - 1'b1;
	end

	assign lk_zero = (lk == '0);

endmodule

// File: design/pm_bus_decode.sv
// ****************************************
// general register selector and W bus
// microoperation decode
// ****************************************

`timescale 1ns/100ps

`include "pm_consts.svh"

module pm_bus_decode (
	input  pm_pkg::pm_state_t       state,
	input  logic [`PM_WORD_W-1:0]   ir,
	input  logic                    in_group,
	input  logic [1:0]              lg,
	input  logic [`PM_REG_W-1:0]    panel_reg_q,
	output logic [`PM_REG_W-1:0]    reg_sel,
	output pm_pkg::w_op_t           w_op
);

	pm_pkg::instr_class_t ir_class;
	logic [`PM_REG_W-1:0] reg_a;
	logic [`PM_REG_W-1:0] reg_b;

	assign ir_class = pm_pkg::instr_class_t'(ir[`PM_CL_LSB +: `PM_CL_W]);
	assign reg_a = ir[`PM_RA_LSB +: `PM_REG_W];
	assign reg_b = ir[`PM_RB_LSB +: `PM_REG_W];

	always_comb begin
		case (state)
			pm_pkg::ST_P0: reg_sel = panel_reg_q;
			pm_pkg::ST_P3: reg_sel = reg_b;
			pm_pkg::ST_P4: reg_sel = in_group ? {1'b0, lg} : reg_a;
			pm_pkg::ST_P5: reg_sel = reg_a;
			default: reg_sel = '0;
		endcase
	end

	always_comb begin
		w_op = pm_pkg::WOP_NONE;
		case (state)
			pm_pkg::ST_P0: w_op = pm_pkg::WOP_R;
			pm_pkg::ST_P4: begin
				if (in_group)
					w_op = pm_pkg::WOP_R;
			end
			// writeback target by class
			pm_pkg::ST_P5: begin
				case (ir_class)
					pm_pkg::CL_REG, pm_pkg::CL_SHIFT: w_op = pm_pkg::WOP_R;
					pm_pkg::CL_MEM: w_op = pm_pkg::WOP_AR;
					pm_pkg::CL_IO: w_op = pm_pkg::WOP_AC;
					pm_pkg::CL_JUMP: w_op = pm_pkg::WOP_IC;
					default: w_op = pm_pkg::WOP_NONE;
				endcase
			end
			default: w_op = pm_pkg::WOP_NONE;
		endcase
	end

endmodule

// File: design/pm_sequencer.sv
// ****************************************
// main state sequencer: P0..P5 and INT,
// instruction register, counter commands
// ****************************************

`timescale 1ns/100ps

`include "pm_consts.svh"

module pm_sequencer (
	input  logic                    setwp,
	input  logic                    __m77,
	input  logic                    go,
	input  logic                    single,
	input  logic                    load_req,
	input  logic                    rdt_valid,
	input  logic [`PM_WORD_W-1:0]   rdt,
	input  logic                    irq,
	input  logic [`PM_MC_W-1:0]     mc,
	input  logic [1:0]              lg,
	input  logic                    lk_zero,
	output pm_pkg::pm_state_t       state,
	output logic [`PM_WORD_W-1:0]   ir,
	output logic                    fetch,
	output logic                    instr_done,
	output logic                    irq_ack,
	output logic                    load_done,
	output logic                    halt_seen,
	output logic                    cycle_end,
	output logic                    in_group,
	output logic                    mc_clr,
	output logic                    mc_inc,
	output logic                    lg_clr,
	output logic                    lg_inc,
	output logic                    lk_load,
	output logic                    lk_dec,
	output logic [`PM_LK_W-1:0]     lk_init
);

	pm_pkg::pm_state_t next_state;
	pm_pkg::instr_class_t w_class;
	logic [`PM_WORD_W-1:0] word;
	logic [`PM_MC_W-1:0] w_mc;
	logic [`PM_MC_W-1:0] mc_last;
	logic w_ind;
	logic enter_p4;
	logic end_instr;

	// in P1 the fields come straight off the data bus
	assign word = (state == pm_pkg::ST_P1) ? rdt : ir;
	assign w_class = pm_pkg::instr_class_t'(word[`PM_CL_LSB +: `PM_CL_W]);
	assign w_ind = word[`PM_IND_BIT];
	assign w_mc = word[`PM_MC_LSB +: `PM_MC_W];
	assign mc_last = w_mc - 1'b1;
	assign lk_init = word[`PM_LK_LSB +: `PM_LK_W];

	always_ff @(posedge setwp or posedge __m77) begin
		if (__m77)
			state <= pm_pkg::ST_WAIT;
		else
			state <= next_state;
	end

	always_ff @(posedge setwp) begin
		if (state == pm_pkg::ST_P1 && rdt_valid)
			ir <= rdt;
	end

	always_comb begin
		next_state = state;
		enter_p4 = 1'b0;
		end_instr = 1'b0;
		load_done = 1'b0;
		halt_seen = 1'b0;
		cycle_end = 1'b0;
		mc_clr = 1'b0;
		mc_inc = 1'b0;
		lg_clr = 1'b0;
		lg_inc = 1'b0;
		lk_load = 1'b0;
		lk_dec = 1'b0;
		case (state)
			pm_pkg::ST_WAIT: begin
				if (load_req)
					next_state = pm_pkg::ST_P0;
				else if (go)
					next_state = pm_pkg::ST_P1;
			end
			pm_pkg::ST_P0: begin
				load_done = 1'b1;
				next_state = go ? pm_pkg::ST_P1 : pm_pkg::ST_WAIT;
			end
			pm_pkg::ST_P1: begin
				if (rdt_valid) begin
					if (w_mc != '0) begin
						mc_clr = 1'b1;
						next_state = pm_pkg::ST_P2;
					end else if (w_ind)
						next_state = pm_pkg::ST_P3;
					else
						enter_p4 = 1'b1;
				end
			end
			pm_pkg::ST_P2: begin
				mc_inc = 1'b1;
				if (mc == mc_last) begin
					if (w_ind)
						next_state = pm_pkg::ST_P3;
					else
						enter_p4 = 1'b1;
				end
			end
			pm_pkg::ST_P3: enter_p4 = 1'b1;
			pm_pkg::ST_P4: begin
				case (w_class)
					pm_pkg::CL_SHIFT: begin
						if (lk_zero)
							next_state = pm_pkg::ST_P5;
						else
							lk_dec = 1'b1;
					end
					pm_pkg::CL_GROUP: begin
						if (lg == 2'd3)
							next_state = pm_pkg::ST_P5;
						else
							lg_inc = 1'b1;
					end
					default: next_state = pm_pkg::ST_P5;
				endcase
			end
			pm_pkg::ST_P5: begin
				halt_seen = (w_class == pm_pkg::CL_HALT);
				if (irq)
					next_state = pm_pkg::ST_INT;
				else
					end_instr = 1'b1;
			end
			pm_pkg::ST_INT: end_instr = 1'b1;
			default: next_state = pm_pkg::ST_WAIT;
		endcase

		// counters are primed on the way into execute
		if (enter_p4) begin
			next_state = pm_pkg::ST_P4;
			lk_load = (w_class == pm_pkg::CL_SHIFT);
			lg_clr = (w_class == pm_pkg::CL_GROUP);
		end

		if (end_instr) begin
			cycle_end = single;
			if (go && !single && w_class != pm_pkg::CL_HALT)
				next_state = pm_pkg::ST_P1;
			else
				next_state = pm_pkg::ST_WAIT;
		end
	end

	assign fetch = (state == pm_pkg::ST_P1);
	assign instr_done = (state == pm_pkg::ST_P5);
	assign irq_ack = (state == pm_pkg::ST_INT);
	assign in_group = (state == pm_pkg::ST_P4) && (w_class == pm_pkg::CL_GROUP);

endmodule

// File: design/pm_top.sv
// ****************************************
// P-M unit top: panel, sequencer, counters
// and bus decoder
// ****************************************

`timescale 1ns/100ps

`include "pm_consts.svh"

module pm_top (
	input  logic                    setwp,
	input  logic                    __m77,
	input  logic                    panel_stb,
	input  pm_pkg::panel_op_t       panel_op,
	input  logic [`PM_REG_W-1:0]    panel_reg,
	input  logic                    rdt_valid,
	input  logic [`PM_WORD_W-1:0]   rdt,
	input  logic                    irq,
	output pm_pkg::pm_state_t       state,
	output logic                    run,
	output logic                    wait_flag,
	output logic                    fetch,
	output logic                    instr_done,
	output logic                    irq_ack,
	output logic [`PM_REG_W-1:0]    reg_sel,
	output pm_pkg::w_op_t           w_op
);

	logic go, single, load_req;
	logic load_done, halt_seen, cycle_end, in_group;
	logic mc_clr, mc_inc, lg_clr, lg_inc, lk_load, lk_dec, lk_zero;
	logic [`PM_LK_W-1:0] lk_init;
	logic [`PM_MC_W-1:0] mc;
	logic [1:0] lg;
	logic [`PM_REG_W-1:0] panel_reg_q;
	logic [`PM_WORD_W-1:0] ir;

	pm_panel_regs u_panel (
		.setwp(setwp), .__m77(__m77), .panel_stb(panel_stb), .panel_op(panel_op),
		.panel_reg(panel_reg), .load_done(load_done), .halt_seen(halt_seen),
		.cycle_end(cycle_end), .go(go), .single(single), .load_req(load_req),
		.run(run), .wait_flag(wait_flag), .panel_reg_q(panel_reg_q)
	);

	pm_sequencer u_seq (
		.setwp(setwp), .__m77(__m77), .go(go), .single(single), .load_req(load_req),
		.rdt_valid(rdt_valid), .rdt(rdt), .irq(irq), .mc(mc), .lg(lg),
		.lk_zero(lk_zero), .state(state), .ir(ir), .fetch(fetch),
		.instr_done(instr_done), .irq_ack(irq_ack), .load_done(load_done),
		.halt_seen(halt_seen), .cycle_end(cycle_end), .in_group(in_group),
		.mc_clr(mc_clr), .mc_inc(mc_inc), .lg_clr(lg_clr), .lg_inc(lg_inc),
		.lk_load(lk_load), .lk_dec(lk_dec), .lk_init(lk_init)
	);

	pm_counters u_cnt (
		.setwp(setwp), .__m77(__m77), .mc_clr(mc_clr), .mc_inc(mc_inc),
		.lg_clr(lg_clr), .lg_inc(lg_inc), .lk_load(lk_load), .lk_dec(lk_dec),
		.lk_init(lk_init), .mc(mc), .lg(lg), .lk_zero(lk_zero)
	);

	pm_bus_decode u_dec (
		.state(state), .ir(ir), .in_group(in_group), .lg(lg),
		.panel_reg_q(panel_reg_q), .reg_sel(reg_sel), .w_op(w_op)
	);

endmodule

// File: tests/pm_props.sv
// ****************************************
// bound checks on sequencer state, done,
// W bus and panel flags
// ****************************************

`timescale 1ns/100ps

module pm_props (
	input logic                setwp,
	input logic                __m77,
	input pm_pkg::pm_state_t   state,
	input logic                instr_done,
	input pm_pkg::w_op_t       w_op,
	input logic                run,
	input logic                wait_flag
);

	// assertion failure count
	int unsigned fails = 0;

	a_state_known: assert property (@(posedge setwp) disable iff (__m77)
		!$isunknown(state))
		else begin
			fails++;
			$error("state holds an unknown value");
		end

	// writeback always follows the last execute cycle
	a_done_after_p4: assert property (@(posedge setwp) disable iff (__m77)
		instr_done |-> $past(state) == pm_pkg::ST_P4)
		else begin
			fails++;
			$error("instr_done without a preceding P4 cycle");
		end

	a_done_once: assert property (@(posedge setwp) disable iff (__m77)
		instr_done |=> !instr_done)
		else begin
			fails++;
			$error("instr_done high two cycles running");
		end

	// W bus idles outside panel load, execute and writeback
	a_wop_idle: assert property (@(posedge setwp) disable iff (__m77)
		!(state inside {pm_pkg::ST_P0, pm_pkg::ST_P4, pm_pkg::ST_P5}) |->
			w_op == pm_pkg::WOP_NONE)
		else begin
			fails++;
			$error("w_op active outside P0, P4 and P5");
		end

	a_wait_leave: assert property (@(posedge setwp) disable iff (__m77)
		state == pm_pkg::ST_WAIT && run |=> state inside {pm_pkg::ST_P0, pm_pkg::ST_P1})
		else begin
			fails++;
			$error("sequencer stayed in WAIT although run was high");
		end

	// only a halt in writeback sets the wait flag
	a_wait_halt: assert property (@(posedge setwp) disable iff (__m77)
		$rose(wait_flag) |-> $past(state) == pm_pkg::ST_P5)
		else begin
			fails++;
			$error("wait_flag rose without a preceding P5 cycle");
		end

endmodule

// File: tests/pm_tb.sv
// ****************************************
// P-M sequencer testbench: data file driven
// state trace, bus decode and panel checks
// ****************************************

`timescale 1ns/100ps

`include "pm_consts.svh"

module pm_tb;

	localparam int MAX_TESTS = 64;
	// worst case cycles of one test line
	localparam int TEST_CYCLES = 32;

	logic setwp;
	logic __m77;
	logic panel_stb;
	pm_pkg::panel_op_t panel_op;
	logic [`PM_REG_W-1:0] panel_reg;
	logic rdt_valid;
	logic [`PM_WORD_W-1:0] rdt;
	logic irq;
	pm_pkg::pm_state_t state;
	logic run;
	logic wait_flag;
	logic fetch;
	logic instr_done;
	logic irq_ack;
	logic [`PM_REG_W-1:0] reg_sel;
	pm_pkg::w_op_t w_op;

	logic [15:0] td [0:6*MAX_TESTS-1];
	logic [15:0] lfsr;
	logic start_m;
	logic wait_m;
	logic single_m;
	pm_pkg::pm_state_t exp_next;
	int n_tests;
	int err_cnt;
	int fail_tests;
	int watch_cycles;

	pm_top uut (
		.setwp(setwp), .__m77(__m77), .panel_stb(panel_stb), .panel_op(panel_op),
		.panel_reg(panel_reg), .rdt_valid(rdt_valid), .rdt(rdt), .irq(irq),
		.state(state), .run(run), .wait_flag(wait_flag), .fetch(fetch),
		.instr_done(instr_done), .irq_ack(irq_ack), .reg_sel(reg_sel), .w_op(w_op)
	);

	bind pm_top pm_props u_props (
		.setwp(setwp), .__m77(__m77), .state(state), .instr_done(instr_done),
		.w_op(w_op), .run(run), .wait_flag(wait_flag)
	);

	always #10 setwp = ~setwp;

	// 16 bit Galois LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic draw_bits(input int n, output logic [3:0] v);
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[2:0], lfsr[0]};
		end
	endtask

	task automatic check_state(input string name, input pm_pkg::pm_state_t got,
			input pm_pkg::pm_state_t exp);
		if (got !== exp) begin
			$display("ERROR %0t: %s is %0d (%s), expected %0d (%s)", $time, name,
				got, got.name(), exp, exp.name());
			err_cnt++;
		end
	endtask

	task automatic check_wop(input string name, input pm_pkg::w_op_t got,
			input pm_pkg::w_op_t exp);
		if (got !== exp) begin
			$display("ERROR %0t: %s is %0d (%s), expected %0d (%s)", $time, name,
				got, got.name(), exp, exp.name());
			err_cnt++;
		end
	endtask

	task automatic check_reg(input string name, input logic [`PM_REG_W-1:0] got,
			input logic [`PM_REG_W-1:0] exp);
		if (got !== exp) begin
			$display("ERROR %0t: %s is %0d, expected %0d", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR %0t: %s is %b, expected %b", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	// one data line drives a panel command and walks the expected state trace
	task automatic run_test(input int t);
		pm_pkg::panel_op_t cmd;
		pm_pkg::instr_class_t cls;
		pm_pkg::pm_state_t trace[$];
		logic [`PM_WORD_W-1:0] word;
		logic [3:0] delay;
		logic [3:0] rnd;
		logic irq_t;
		logic run_exp;
		logic wait_exp;
		logic [`PM_REG_W-1:0] grp;
		logic [`PM_REG_W-1:0] ra;
		logic [`PM_REG_W-1:0] rb;
		int n_p4;
		int p1_seen;
		int errs_before;

		errs_before = err_cnt;
		cmd = pm_pkg::panel_op_t'(td[6*t][2:0]);
		word = td[6*t+1];
		cls = pm_pkg::instr_class_t'(word[`PM_CL_LSB +: `PM_CL_W]);
		ra = word[`PM_RA_LSB +: `PM_REG_W];
		rb = word[`PM_RB_LSB +: `PM_REG_W];
		if (td[6*t+2] == 16'h000f)
			draw_bits(2, delay);
		else
			delay = td[6*t+2][3:0];
		if (td[6*t+3] == 16'h000f) begin
			draw_bits(1, rnd);
			irq_t = rnd[0];
		end else
			irq_t = td[6*t+3][0];

		// strobe cycle plus the cycle in which the flags take effect
		if (cmd == pm_pkg::PNL_START || cmd == pm_pkg::PNL_CYCLE ||
				cmd == pm_pkg::PNL_LOAD) begin
			trace.push_back(pm_pkg::ST_WAIT);
			trace.push_back(pm_pkg::ST_WAIT);
		end
		if (cmd == pm_pkg::PNL_LOAD)
			trace.push_back(pm_pkg::ST_P0);
		else begin
			repeat (delay + 1) trace.push_back(pm_pkg::ST_P1);
			repeat (word[`PM_MC_LSB +: `PM_MC_W]) trace.push_back(pm_pkg::ST_P2);
			if (word[`PM_IND_BIT])
				trace.push_back(pm_pkg::ST_P3);
			if (cls == pm_pkg::CL_SHIFT)
				n_p4 = word[`PM_LK_LSB +: `PM_LK_W] + 1;
			else if (cls == pm_pkg::CL_GROUP)
				n_p4 = 4;
			else
				n_p4 = 1;
			repeat (n_p4) trace.push_back(pm_pkg::ST_P4);
			trace.push_back(pm_pkg::ST_P5);
			if (irq_t)
				trace.push_back(pm_pkg::ST_INT);
		end

		// panel flag model
		run_exp = start_m & ~wait_m;
		wait_exp = wait_m;
		case (cmd)
			pm_pkg::PNL_START: begin
				start_m = 1'b1;
				wait_m = 1'b0;
				single_m = 1'b0;
			end
			pm_pkg::PNL_CYCLE: begin
				start_m = 1'b1;
				single_m = 1'b1;
			end
			pm_pkg::PNL_STOP: start_m = 1'b0;
			default: ;
		endcase
		if (cmd == pm_pkg::PNL_LOAD)
			exp_next = (start_m && !wait_m) ? pm_pkg::ST_P1 : pm_pkg::ST_WAIT;
		else begin
			exp_next = (start_m && !wait_m && !single_m && cls != pm_pkg::CL_HALT) ?
				pm_pkg::ST_P1 : pm_pkg::ST_WAIT;
			if (cls == pm_pkg::CL_HALT)
				wait_m = 1'b1;
			if (single_m)
				start_m = 1'b0;
		end

		p1_seen = 0;
		grp = '0;
		for (int i = 0; i < trace.size(); i++) begin
			@(posedge setwp);
			#2;
			panel_stb = (i == 0) && (cmd != pm_pkg::PNL_NONE);
			panel_op = (i == 0) ? cmd : pm_pkg::PNL_NONE;
			panel_reg = word[`PM_REG_W-1:0];
			rdt = word;
			rdt_valid = (trace[i] == pm_pkg::ST_P1) && (p1_seen == delay);
			irq = irq_t && (trace[i] == pm_pkg::ST_P5);
			@(negedge setwp);
			check_state("state", state, trace[i]);
			check_bit("fetch", fetch, trace[i] == pm_pkg::ST_P1);
			check_bit("instr_done", instr_done, trace[i] == pm_pkg::ST_P5);
			check_bit("irq_ack", irq_ack, trace[i] == pm_pkg::ST_INT);
			if (i == 0) begin
				check_bit("run", run, run_exp);
				check_bit("wait_flag", wait_flag, wait_exp);
			end
			case (trace[i])
				pm_pkg::ST_P0: begin
					check_reg("reg_sel", reg_sel, td[6*t+4][`PM_REG_W-1:0]);
					check_wop("w_op", w_op, pm_pkg::w_op_t'(td[6*t+5][2:0]));
				end
				pm_pkg::ST_P1: p1_seen++;
				pm_pkg::ST_P3: check_reg("reg_sel", reg_sel, rb);
				pm_pkg::ST_P4: begin
					if (cls == pm_pkg::CL_GROUP) begin
						check_reg("reg_sel", reg_sel, grp);
						check_wop("w_op", w_op, pm_pkg::WOP_R);
						grp++;
					end else begin
						check_reg("reg_sel", reg_sel, ra);
						check_wop("w_op", w_op, pm_pkg::WOP_NONE);
					end
				end
				pm_pkg::ST_P5: begin
					check_reg("reg_sel", reg_sel, td[6*t+4][`PM_REG_W-1:0]);
					check_wop("w_op", w_op, pm_pkg::w_op_t'(td[6*t+5][2:0]));
				end
				default: ;
			endcase
		end

		if (err_cnt == errs_before)
			$display("test %0d: %s word %h delay %0d irq %b ok", t, cmd.name(), word,
				delay, irq_t);
		else begin
			$display("test %0d: %s word %h delay %0d irq %b failed, %0d errors", t,
				cmd.name(), word, delay, irq_t, err_cnt - errs_before);
			fail_tests++;
		end
	endtask

	initial begin
		setwp = 1'b0;
		__m77 = 1'b1;
		panel_stb = 1'b0;
		panel_op = pm_pkg::PNL_NONE;
		panel_reg = '0;
		rdt_valid = 1'b0;
		rdt = '0;
		irq = 1'b0;
		lfsr = 16'd4;
		start_m = 1'b0;
		wait_m = 1'b0;
		single_m = 1'b0;
		exp_next = pm_pkg::ST_WAIT;
		err_cnt = 0;
		fail_tests = 0;
		n_tests = 0;

		$readmemh("tests/pm_testdata.txt", td);
		while (n_tests < MAX_TESTS && !$isunknown(td[6*n_tests]) &&
				td[6*n_tests] != 16'h000f)
			n_tests++;
		if (n_tests == 0 || n_tests == MAX_TESTS || td[6*n_tests] !== 16'h000f) begin
			$display("test data file is missing or has no end line");
			err_cnt++;
		end
		watch_cycles = 12 + n_tests * TEST_CYCLES + 40;

		repeat (10) @(posedge setwp);
		#2;
		__m77 = 1'b0;
		@(negedge setwp);
		check_state("state", state, pm_pkg::ST_WAIT);
		check_bit("run", run, 1'b0);
		check_wop("w_op", w_op, pm_pkg::WOP_NONE);

		for (int t = 0; t < n_tests; t++)
			run_test(t);

		// where the last instruction left the sequencer
		@(posedge setwp);
		#2;
		@(negedge setwp);
		check_state("state", state, exp_next);
		check_bit("run", run, start_m & ~wait_m);
		check_bit("wait_flag", wait_flag, wait_m);

		$display("summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
			n_tests, fail_tests, err_cnt, uut.u_props.fails);
		if (err_cnt == 0 && uut.u_props.fails == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		wait (watch_cycles > 0);
		repeat (watch_cycles) @(posedge setwp);
		$display("watchdog: run did not end within %0d cycles, sequencer appears hung",
			watch_cycles);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: tests/pm_testdata.txt
// cmd word delay irq reg_sel w_op, hex; cmd 0 none 1 start 2 stop 3 cycle 4 load, f ends
// delay or irq of f comes from the LFSR; reg_sel and w_op are checked in P5, or in P0 for a load
// panel loads after reset
4 0005 0 0 5 1
4 0002 0 0 2 1
// plain classes with fetch delays
1 0c80 0 0 3 1
0 3800 1 0 6 3
0 8800 2 0 2 2
0 bc00 3 0 7 4
0 0400 f 0 1 1
// premodification and indirect
0 3110 0 0 4 3
0 15e0 0 0 5 1
0 8330 2 0 0 2
0 abc0 0 0 2 4
0 2ef0 1 0 3 3
// shift and group execute
0 4400 0 0 1 1
0 5805 0 0 6 1
0 4a5f 1 0 2 1
0 7000 0 0 4 0
0 7ce0 0 0 7 0
// interrupts, nop and halt
0 0c00 0 1 3 1
0 b400 0 0 5 4
0 2400 0 f 1 3
0 f800 0 0 6 0
0 c800 0 0 2 0
// resume after halt, then stop mid instruction
1 1000 0 0 4 1
0 4003 0 1 0 1
2 9550 2 0 5 2
// single cycle runs
3 ac00 0 0 3 4
3 6400 1 1 1 0
4 0007 0 0 7 1
1 2800 f f 2 3
0 d800 0 1 6 0
4 0003 0 0 3 1
1 5c21 0 0 7 1
2 0000 3 0 0 1
3 9000 0 f 4 2
// end of tests
f 0000 0 0 0 0

// File: all.f
+incdir+design
design/pm_pkg.sv
design/pm_panel_regs.sv
design/pm_counters.sv
design/pm_bus_decode.sv
design/pm_sequencer.sv
design/pm_top.sv
tests/pm_props.sv
tests/pm_tb.sv

// File: Bender.yml
package:
  name: pm_sequencer

sources:
  - include_dirs:
      - design
    files:
      - design/pm_pkg.sv
      - design/pm_panel_regs.sv
      - design/pm_counters.sv
      - design/pm_bus_decode.sv
      - design/pm_sequencer.sv
      - design/pm_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/pm_props.sv
      - tests/pm_tb.sv
